// ==== rtl/packPkg.sv ====
package packPkg;

  // stream and output widths
  typedef logic [7:0]  byteT;     // one byte of the serial stream
  typedef logic [15:0] half16T;   // 16-bit output word
  typedef logic [31:0] word32T;   // 32-bit output word, also the assembly register

  // raw select as it arrives on the port
  // 00 and 11 give 8 bits, 01 gives 16 bits, 10 gives 32 bits
  typedef logic [1:0] widthSelT;

  // byte index inside the word being built
  typedef logic [1:0] byteCountT;

  // decoded width, shared by decode, packer and latch
  typedef enum logic [1:0] {
    MODE8  = 2'd0,
    MODE16 = 2'd1,
    MODE32 = 2'd2
  } packModeE;

  // completed word handed from packer to latch
  // data is right-aligned, bits above the mode width are zero
  typedef struct packed {
    packModeE mode;   // width this word was assembled with
    word32T   data;   // assembled bytes, first byte most significant
  } packWordS;        // 34 bits

  // index of the last byte of a word per mode
  localparam byteCountT LAST8  = 2'd0;
  localparam byteCountT LAST16 = 2'd1;
  localparam byteCountT LAST32 = 2'd3;

  // raw select codes
  localparam widthSelT SEL8A  = 2'b00;
  localparam widthSelT SEL16  = 2'b01;
  localparam widthSelT SEL32  = 2'b10;
  localparam widthSelT SEL8B  = 2'b11;

endpackage

// ==== rtl/widthDecode.sv ====
module widthDecode import packPkg::*; (
  input  logic     clk8,
  input  logic     rst,
  input  widthSelT dataS,    // raw width select from the port
  input  logic     wordEnd,  // from packer, safe point to switch width
  output packModeE mode      // width used for the word under assembly
);

  packModeE selMode;  // combinational decode of dataS

  // map the two-bit select onto the three widths
  // both 00 and 11 fall back to byte mode
  always_comb begin
    case (dataS)
      SEL16:   selMode = MODE16;
      SEL32:   selMode = MODE32;
      SEL8A:   selMode = MODE8;
      SEL8B:   selMode = MODE8;
      default: selMode = MODE8;  // x on the select, stay in byte mode
    endcase
  end

  // active width only moves at a word boundary,
  // so a word in progress never sees a new select
  always_ff @(posedge clk8) begin
    if (rst) begin
      mode <= MODE8;         // byte mode out of reset
    end else if (wordEnd) begin
      mode <= selMode;       // boundary, take the new width
    end
  end

  // note that while the stream is idle and no word is open,
  // wordEnd stays high and mode follows dataS with one cycle lag,
  // which gives the first byte after a boundary the new width

endmodule

// ==== rtl/bytePacker.sv ====
module bytePacker import packPkg::*; (
  input  logic     clk8,
  input  logic     rst,
  input  logic     enb,      // byte strobe, one byte per cycle when high
  input  byteT     dataIn,   // serial byte
  input  packModeE mode,     // active width from decode
  output logic     wordEnd,  // boundary, decode may load a new width
  output logic     done,     // one-cycle pulse with a finished word
  output packWordS word      // finished word and its width
);

  byteCountT count;      // index of the next byte inside the word
  logic      wordOpen;   // at least one byte of a word has been taken
  word32T    asmReg;     // word under assembly, right-aligned
  word32T    asmNext;    // asmReg with the current byte shifted in
  byteCountT lastIdx;    // last byte index for the active width
  logic      isLast;     // current byte closes the word

  // last index depends only on the active width
  always_comb begin
    case (mode)
      MODE16:  lastIdx = LAST16;
      MODE32:  lastIdx = LAST32;
      default: lastIdx = LAST8;
    endcase
  end

  assign isLast = (count == lastIdx);

  // shift left by one byte and drop the new one in at the bottom
  // first byte of a word starts from zero so older bytes never leak in
  always_comb begin
    if (count == '0) begin
      asmNext = {24'd0, dataIn};
    end else begin
      asmNext = {asmReg[23:0], dataIn};
    end
  end

  // boundary: last byte accepted now, or idle with no word open
  // an idle cycle inside a word keeps the width frozen
  assign wordEnd = enb ? isLast : ~wordOpen;

  // control state: count, open flag, done pulse
  always_ff @(posedge clk8) begin
    if (rst) begin
      count    <= '0;
      wordOpen <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= enb & isLast;        // pulse for exactly one cycle
      if (enb) begin
        if (isLast) begin
          count    <= '0;          // word closed, restart at byte 0
          wordOpen <= 1'b0;
        end else begin
          count    <= count + 2'd1;
          wordOpen <= 1'b1;        // more bytes to come
        end
      end
    end
  end

  // payload path, enb low holds everything
  always_ff @(posedge clk8) begin
    if (enb) begin
      asmReg <= asmNext;
      if (isLast) begin
        word.mode <= mode;         // tag with the width it was built in
        word.data <= asmNext;      // visible with done in the next cycle
      end
    end
  end

endmodule

// ==== rtl/wordLatch.sv ====
module wordLatch import packPkg::*; (
  input  logic     clk8,
  input  logic     rst,
  input  logic     done,       // finished word from the packer
  input  packWordS word,
  output byteT     dataOut,    // last 8-bit word
  output half16T   dataOut16,  // last 16-bit word
  output word32T   dataOut32,  // last 32-bit word
  output logic     valid8,     // one-cycle pulse per new 8-bit word
  output logic     valid16,
  output logic     valid32
);

  // only the port of the word's own width is written,
  // the other two hold their last values
  always_ff @(posedge clk8) begin
    if (rst) begin
      dataOut   <= '0;
      dataOut16 <= '0;
      dataOut32 <= '0;
      valid8    <= 1'b0;
      valid16   <= 1'b0;
      valid32   <= 1'b0;
    end else begin
      valid8  <= 1'b0;    // pulses drop unless a word lands now
      valid16 <= 1'b0;
      valid32 <= 1'b0;
      if (done) begin
        case (word.mode)
          MODE16: begin
            dataOut16 <= word.data[15:0];  // low half, data is right-aligned
            valid16   <= 1'b1;
          end
          MODE32: begin
            dataOut32 <= word.data;
            valid32   <= 1'b1;
          end
          default: begin
            dataOut <= word.data[7:0];     // byte mode
            valid8  <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

// ==== rtl/byteToWord.sv ====
module byteToWord import packPkg::*; (
  input  logic     clk8,
  input  logic     rst,
  input  logic     enb,        // byte strobe
  input  byteT     dataIn,     // serial byte stream
  input  widthSelT dataS,      // width select, applied at word boundaries
  output byteT     dataOut,    // 8-bit result
  output half16T   dataOut16,  // 16-bit result
  output word32T   dataOut32,  // 32-bit result
  output logic     valid8,
  output logic     valid16,
  output logic     valid32
);

  packModeE mode;      // active width
  logic     wordEnd;   // boundary back from the packer
  logic     done;      // word finished
  packWordS word;      // finished word with its width

  // width select, frozen while a word is open
  widthDecode u_widthDecode (
    .clk8    (clk8),
    .rst     (rst),
    .dataS   (dataS),
    .wordEnd (wordEnd),
    .mode    (mode)
  );

  // byte assembly
  bytePacker u_bytePacker (
    .clk8    (clk8),
    .rst     (rst),
    .enb     (enb),
    .dataIn  (dataIn),
    .mode    (mode),
    .wordEnd (wordEnd),
    .done    (done),
    .word    (word)
  );

  // per-width output registers and valid pulses
  wordLatch u_wordLatch (
    .clk8      (clk8),
    .rst       (rst),
    .done      (done),
    .word      (word),
    .dataOut   (dataOut),
    .dataOut16 (dataOut16),
    .dataOut32 (dataOut32),
    .valid8    (valid8),
    .valid16   (valid16),
    .valid32   (valid32)
  );

endmodule

// ==== dv/byteToWordTb.sv ====
module byteToWordTb;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk8 = 1'b0;
  logic        rst;
  logic        enb;
  logic [7:0]  dataIn;
  logic [1:0]  dataS;
  logic [7:0]  dataOut;
  logic [15:0] dataOut16;
  logic [31:0] dataOut32;
  logic        valid8;
  logic        valid16;
  logic        valid32;

  logic [31:0] lfsr = 32'h2532_49ae;  // stimulus source
  int          expWidth[$];            // width of each word still to come out
  logic [31:0] expData[$];             // its expected value
  int          expDue[$];              // negedge count at which its valid must be seen
  int          negCount = 0;

  // reference state of the DUT as the boundary rule predicts it
  int          refWidth = 8;
  logic [1:0]  refCount = 2'd0;
  logic        refOpen = 1'b0;
  logic [7:0]  curBytes [4];

  // last value seen on each data port
  logic [31:0] last8 = '0;
  logic [31:0] last16 = '0;
  logic [31:0] last32 = '0;

  byteToWord u_byteToWord (
    .clk8      (clk8),
    .rst       (rst),
    .enb       (enb),
    .dataIn    (dataIn),
    .dataS     (dataS),
    .dataOut   (dataOut),
    .dataOut16 (dataOut16),
    .dataOut32 (dataOut32),
    .valid8    (valid8),
    .valid16   (valid16),
    .valid32   (valid32)
  );

  always #4 clk8 = ~clk8;  // 8 ns period

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] stepLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = stepLfsr(lfsr);  // one step per bit
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // 01 is 16 bits, 10 is 32 bits, 00 and 11 are bytes
  function automatic int widthOfSel(input logic [1:0] sel);
    case (sel)
      2'b01:   return 16;
      2'b10:   return 32;
      default: return 8;
    endcase
  endfunction

  // expected word with the first byte most significant
  function automatic logic [31:0] expectedWord(input int width, input logic [7:0] bytes [4]);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < width / 8; i++) begin
      result = {result[23:0], bytes[i[1:0]]};
    end
    return result;
  endfunction

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else
      reportFail($sformatf("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act));
  endtask

  // one clock of stimulus and the reference model for the edge that samples it
  task automatic driveCycle(input logic en, input logic [7:0] data, input logic [1:0] sel);
    logic [1:0] lastIdx;
    logic       wordEndNow;
    @(posedge clk8);
    enb    <= en;
    dataIn <= data;
    dataS  <= sel;
    lastIdx    = 2'(refWidth / 8 - 1);
    wordEndNow = en ? (refCount == lastIdx) : ~refOpen;  // boundary at that edge
    if (en) begin
      curBytes[refCount] = data;
      if (refCount == lastIdx) begin
        expWidth.push_back(refWidth);
        expData.push_back(expectedWord(refWidth, curBytes));
        expDue.push_back(negCount + 3);  // sampled at the next edge and valid two edges later
        refCount = 2'd0;
        refOpen  = 1'b0;
      end else begin
        refCount = refCount + 2'd1;
        refOpen  = 1'b1;
      end
    end
    if (wordEndNow) refWidth = widthOfSel(sel);  // new width only at a boundary
  endtask

  task automatic randomCycle(input logic [1:0] sel);
    logic [31:0] v;
    logic        en;
    takeBits(2, v);
    en = (v[1:0] != 2'b00);  // roughly three in four cycles carry a byte
    takeBits(8, v);
    driveCycle(en, v[7:0], sel);
  endtask

  task automatic burst(input int n, input logic [1:0] sel);
    logic [31:0] v;
    repeat (n) begin
      takeBits(8, v);
      driveCycle(1'b1, v[7:0], sel);  // back-to-back words without gaps
    end
  endtask

  // compare on the falling edge where outputs are settled
  always @(negedge clk8) begin
    int nValid;
    int w;
    int gotWidth;
    int due;
    logic [31:0] d;
    negCount = negCount + 1;
    if (!rst) begin
      nValid = int'(valid8) + int'(valid16) + int'(valid32);
      assert (nValid <= 1) else reportFail("more than one valid output is high in one cycle");
      if (nValid == 1) begin
        assert (expWidth.size() > 0) else reportFail("valid pulse arrived with no word expected");
        w = expWidth.pop_front();
        d = expData.pop_front();
        due = expDue.pop_front();
        gotWidth = valid8 ? 8 : (valid16 ? 16 : 32);
        assert (gotWidth == w) else
          reportFail($sformatf("a %0d-bit valid pulse came where a %0d-bit word was expected",
                               gotWidth, w));
        assert (due == negCount) else
          reportFail($sformatf("MISMATCH at %0t: valid%0d cycle expected %0d actual %0d",
                               $time, w, due, negCount));
        if (w == 8) last8 = d;
        else if (w == 16) last16 = d;
        else last32 = d;
      end else if (expDue.size() > 0) begin
        assert (expDue[0] > negCount) else reportFail("an expected valid pulse never arrived");
      end
      // every port either took the new word or holds its last one
      checkValue("dataOut", last8, 32'(dataOut));
      checkValue("dataOut16", last16, 32'(dataOut16));
      checkValue("dataOut32", last32, dataOut32);
    end
  end

  initial begin
    int wait8;
    rst    <= 1'b1;
    enb    <= 1'b0;
    dataIn <= 8'h00;
    dataS  <= 2'b00;
    repeat (4) @(posedge clk8);
    rst <= 1'b0;

    repeat (6) driveCycle(1'b0, 8'h00, 2'b00);  // idle so outputs stay zero
    burst(8, 2'b00);                            // byte mode with select 00
    repeat (12) randomCycle(2'b11);             // byte mode with select 11 and gaps
    burst(8, 2'b01);
    repeat (24) randomCycle(2'b01);
    burst(12, 2'b10);
    repeat (40) randomCycle(2'b10);
    while (refCount != 2'd0) burst(1, 2'b10);   // close the open 32-bit word

    // width change inside a 32-bit word and then a 16-bit word
    burst(2, 2'b10);
    burst(4, 2'b01);
    burst(3, 2'b00);
    repeat (3) driveCycle(1'b0, 8'h00, 2'b11);

    // random select with random strobe
    repeat (300) begin
      logic [31:0] v;
      takeBits(3, v);
      if (v[2:0] == 3'd0) begin
        takeBits(2, v);
        randomCycle(v[1:0]);  // occasional select change that often lands mid-word
      end else begin
        randomCycle(dataS);
      end
    end

    driveCycle(1'b0, 8'h00, 2'b00);
    wait8 = 0;
    while (expWidth.size() != 0 && wait8 < 20) begin  // drain with a cycle limit
      @(posedge clk8);
      wait8++;
    end
    if (expWidth.size() != 0) begin
      reportFail("words were still expected when the drain timed out");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== project.f ====
rtl/packPkg.sv
rtl/widthDecode.sv
rtl/bytePacker.sv
rtl/wordLatch.sv
rtl/byteToWord.sv
dv/byteToWordTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the byteToWord testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module byteToWordTb -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/VbyteToWordTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
